//--- rv_exec_top.f
design/rv_exec_pkg.sv
design/dec_bus_if.sv
design/inst_decoder.sv
design/idu_id_pipe.sv
design/gpr_file.sv
design/exu_alu_stage.sv
design/pipe_ctrl.sv
design/rv_exec_top.sv
bench/tb_rv_exec_top.sv

//--- Makefile
# Verilator build and run for the rv_exec_top testbench

TOP = tb_rv_exec_top

compile:
	verilator --binary --timing --timescale 1ns/100ps -f rv_exec_top.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: compile run clean

//--- bench/tb_rv_exec_top.sv
// Testbench for rv_exec_top. inst_valid_i stays high until the table is used up,
// so each taken branch or jump discards exactly the next two table entries.
module tb_rv_exec_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_exec_pkg::*;

    localparam int I_ALU   = 'h13;    // op-imm
    localparam int I_LUI   = 'h37;
    localparam int I_AUIPC = 'h17;
    localparam int I_JALR  = 'h67;
    localparam int I_LOAD  = 'h03;    // not supported by the DUT

    logic       clk;
    logic       rst_n_i;
    logic       inst_valid_i;
    logic       inst_ready_o;
    inst_addr_t inst_addr_i;
    inst_t      inst_i;
    logic       wb_valid_o;
    logic       wb_ready_i;
    reg_addr_t  wb_waddr_o;
    xlen_t      wb_wdata_o;
    logic       redirect_o;
    inst_addr_t redirect_addr_o;

    inst_addr_t  tbl_addr[$];
    inst_t       tbl_inst[$];
    logic        tbl_flush[$];    // entry expected to be discarded
    reg_addr_t   exp_wb_addr[$];
    xlen_t       exp_wb_data[$];
    inst_addr_t  exp_redir[$];
    logic [31:0] lfsr_state;
    int          wb_errs = 0;
    int          redir_errs = 0;
    int          ctrl_errs = 0;
    int          cycle_cnt = 0;
    int          timeout_limit = 1000;

    rv_exec_top UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .inst_ready_o    (inst_ready_o),
        .inst_addr_i     (inst_addr_i),
        .inst_i          (inst_i),
        .wb_valid_o      (wb_valid_o),
        .wb_ready_i      (wb_ready_i),
        .wb_waddr_o      (wb_waddr_o),
        .wb_wdata_o      (wb_wdata_o),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders
    function automatic inst_t enc_i(input int opc, input int f3, input int rd,
                                    input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic inst_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic inst_t enc_b(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_u(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic inst_t enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // galois lfsr, one bit out per step
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                        input xlen_t a, input xlen_t b);
        xlen_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];    // keeps the sign
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic add_entry(input inst_addr_t addr, input inst_t w, input logic fl);
        tbl_addr.push_back(addr);
        tbl_inst.push_back(w);
        tbl_flush.push_back(fl);
    endtask

    task automatic fill_table();
        add_entry(32'd0,   enc_i(I_ALU, 0, 1, 0, 5), 1'b0);        // addi x1, x0, 5
        add_entry(32'd4,   enc_i(I_ALU, 0, 2, 0, -3), 1'b0);       // addi x2, x0, -3
        add_entry(32'd8,   enc_r(0, 2, 1, 0, 3), 1'b0);            // add x3, x1, x2
        add_entry(32'd12,  enc_r('h20, 1, 3, 0, 4), 1'b0);         // sub x4, x3, x1
        add_entry(32'd16,  enc_i(I_ALU, 1, 5, 4, 4), 1'b0);        // slli x5, x4, 4
        add_entry(32'd20,  enc_i(I_ALU, 5, 6, 5, 'h402), 1'b0);    // srai x6, x5, 2
        add_entry(32'd24,  enc_i(I_ALU, 5, 7, 5, 28), 1'b0);       // srli x7, x5, 28
        add_entry(32'd28,  enc_r(0, 1, 4, 2, 8), 1'b0);            // slt x8, x4, x1
        add_entry(32'd32,  enc_r(0, 1, 4, 3, 9), 1'b0);            // sltu x9, x4, x1
        add_entry(32'd36,  enc_i(I_ALU, 4, 10, 7, 'h3c), 1'b0);    // xori x10, x7, 0x3c
        add_entry(32'd40,  enc_r(0, 6, 10, 7, 11), 1'b0);          // and x11, x10, x6
        add_entry(32'd44,  enc_u(I_LUI, 12, 'h12345), 1'b0);
        add_entry(32'd48,  enc_u(I_AUIPC, 13, 1), 1'b0);
        add_entry(32'd52,  enc_i(I_ALU, 0, 0, 1, 7), 1'b0);        // rd x0, no writeback
        add_entry(32'd56,  enc_i(I_LOAD, 2, 14, 1, 0), 1'b0);      // lw, must not write x14
        add_entry(32'd60,  enc_r(0, 1, 14, 6, 14), 1'b0);          // or x14, x14, x1
        add_entry(32'd64,  enc_b(0, 1, 3, 16), 1'b0);              // beq, not taken
        add_entry(32'd68,  enc_b(1, 1, 3, 12), 1'b0);              // bne to 80
        add_entry(32'd72,  enc_i(I_ALU, 0, 15, 0, 99), 1'b1);
        add_entry(32'd76,  enc_i(I_ALU, 0, 16, 0, 98), 1'b1);
        add_entry(32'd80,  enc_j(17, 12), 1'b0);                   // jal x17 to 92
        add_entry(32'd84,  enc_j(25, -84), 1'b1);                  // discarded jump
        add_entry(32'd88,  enc_i(I_ALU, 0, 1, 0, 1), 1'b1);        // would clobber x1
        add_entry(32'd92,  enc_i(I_JALR, 0, 18, 1, 'h78), 1'b0);   // 0x7d, bit 0 cleared
        add_entry(32'd96,  enc_i(I_ALU, 0, 22, 0, 1), 1'b1);
        add_entry(32'd100, enc_i(I_ALU, 0, 23, 0, 2), 1'b1);
        add_entry(32'd124, enc_b(4, 4, 1, 8), 1'b0);               // blt to 132
        add_entry(32'd128, enc_b(0, 0, 0, -8), 1'b1);              // discarded beq
        add_entry(32'd132, enc_i(I_ALU, 0, 24, 0, 3), 1'b1);
        add_entry(32'd132, enc_b(7, 1, 4, 8), 1'b0);               // bgeu, not taken
        add_entry(32'd136, enc_r('h20, 1, 2, 5, 19), 1'b0);        // sra x19, x2, x1
        add_entry(32'd140, enc_r(0, 17, 18, 0, 20), 1'b0);         // add x20, x18, x17
        add_entry(32'd144, 32'h0000_0073, 1'b0);                   // ecall, bubble
        add_entry(32'd148, enc_j(0, 8), 1'b0);                     // jal x0 to 156
        add_entry(32'd152, enc_i(I_ALU, 0, 26, 0, 4), 1'b1);
        add_entry(32'd156, enc_i(I_ALU, 0, 27, 0, 5), 1'b1);
        add_entry(32'd156, enc_i(I_ALU, 0, 21, 20, 12), 1'b0);
        add_entry(32'd160, enc_i(I_ALU, 0, 21, 21, 1), 1'b0);      // back to back on x21
    endtask

    // isa reference, builds the expected writeback and redirect queues
    task automatic run_model();
        xlen_t      regs_m [32];
        int         skip;
        inst_t      w;
        inst_addr_t pc;
        inst_addr_t tgt;
        reg_addr_t  rd;
        logic [2:0] f3;
        xlen_t      a, b, imm_i, imm_b, imm_j, imm_u, res;
        logic       wr, taken, gone;
        foreach (regs_m[i]) regs_m[i] = '0;
        skip = 0;
        foreach (tbl_inst[n]) begin
            w     = tbl_inst[n];
            pc    = tbl_addr[n];
            gone  = (skip > 0);
            f3    = w[14:12];
            rd    = w[11:7];
            a     = regs_m[w[19:15]];
            b     = regs_m[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            imm_u = {w[31:12], 12'b0};
            wr    = 1'b0;
            taken = 1'b0;
            res   = '0;
            tgt   = pc + imm_b;
            if (gone !== tbl_flush[n]) begin
                $display("table entry %0d at %h: flush flag disagrees with model", n, pc);
                ctrl_errs++;
            end
            if (gone) begin
                skip--;
            end else begin
                case (w[6:0])
                    7'h13: begin
                        wr  = 1'b1;
                        res = alu_model(f3, (f3 == 3'd5) && w[30], a, imm_i);    // srai only
                    end
                    7'h33: begin
                        wr  = 1'b1;
                        res = alu_model(f3, w[30], a, b);
                    end
                    7'h37: begin
                        wr  = 1'b1;
                        res = imm_u;
                    end
                    7'h17: begin
                        wr  = 1'b1;
                        res = pc + imm_u;
                    end
                    7'h6f: begin
                        wr    = 1'b1;
                        res   = pc + 32'd4;
                        taken = 1'b1;
                        tgt   = pc + imm_j;
                    end
                    7'h67: begin
                        wr    = 1'b1;
                        res   = pc + 32'd4;
                        taken = 1'b1;
                        tgt   = (a + imm_i) & ~32'd1;
                    end
                    7'h63: begin
                        case (f3)
                            3'd0: taken = (a == b);
                            3'd1: taken = (a != b);
                            3'd4: taken = ($signed(a) < $signed(b));
                            3'd5: taken = ($signed(a) >= $signed(b));
                            3'd6: taken = (a < b);
                            3'd7: taken = (a >= b);
                            default: taken = 1'b0;
                        endcase
                    end
                    default: ;    // unsupported, no effect
                endcase
                if (wr && rd != '0) begin
                    regs_m[rd] = res;
                    exp_wb_addr.push_back(rd);
                    exp_wb_data.push_back(res);
                end
                if (taken) begin
                    exp_redir.push_back(tgt);
                    skip = 2;    // decoder and input slot
                end
            end
        end
    endtask

    task automatic check_wb(input reg_addr_t exp_addr, input xlen_t exp_data);
        if (wb_waddr_o !== exp_addr) begin
            $display("Error wb_waddr_o: got %h, expected %h at %0t", wb_waddr_o, exp_addr, $time);
            wb_errs++;
        end
        if (wb_wdata_o !== exp_data) begin
            $display("Error wb_wdata_o: got %h, expected %h at %0t", wb_wdata_o, exp_data, $time);
            wb_errs++;
        end
    endtask

    task automatic check_redirect(input inst_addr_t exp_addr);
        if (redirect_addr_o !== exp_addr) begin
            $display("Error redirect_addr_o: got %h, expected %h at %0t",
                     redirect_addr_o, exp_addr, $time);
            redir_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
            ctrl_errs++;
        end
    endtask

    task automatic send_all();
        int idx;
        idx = 0;
        while (idx < tbl_inst.size()) begin
            @(posedge clk);
            inst_valid_i <= 1'b1;
            inst_addr_i  <= tbl_addr[idx];
            inst_i       <= tbl_inst[idx];
            @(negedge clk);
            if (inst_ready_o) begin
                idx++;    // handshake on the coming edge
            end
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
    endtask

    // random back-pressure on the writeback port
    initial begin
        wb_ready_i = 1'b0;
        lfsr_state = 32'd77815;
        forever begin
            @(posedge clk);
            if (rst_n_i) begin
                wb_ready_i <= lfsr_step();
            end
        end
    end

    // outputs sampled mid-cycle, a transfer follows on the next edge
    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (exp_wb_addr.size() == 0) begin
                $display("unexpected writeback to x%0d with %h", wb_waddr_o, wb_wdata_o);
                wb_errs++;
            end else begin
                check_wb(exp_wb_addr.pop_front(), exp_wb_data.pop_front());
            end
        end
        if (rst_n_i && redirect_o) begin
            if (exp_redir.size() == 0) begin
                $display("unexpected redirect to %h", redirect_addr_o);
                redir_errs++;
            end else begin
                check_redirect(exp_redir.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d writebacks and %0d redirects missing",
                     cycle_cnt, exp_wb_addr.size(), exp_redir.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_addr_i  = '0;
        inst_i       = '0;
        fill_table();
        timeout_limit = 40 * tbl_inst.size();
        run_model();
        repeat (2) @(posedge clk);
        @(negedge clk);    // still in reset
        check_flag("inst_ready_o", inst_ready_o, 1'b0);
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
        check_flag("redirect_o", redirect_o, 1'b0);
        @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(negedge clk);
        check_flag("inst_ready_o", inst_ready_o, 1'b1);
        send_all();
        while (exp_wb_addr.size() != 0 || exp_redir.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);    // room for stray outputs
        $display("errors: writeback %0d, redirect %0d, control %0d",
                 wb_errs, redir_errs, ctrl_errs);
        if (wb_errs + redir_errs + ctrl_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- design/rv_exec_top.sv
// RV32I decode/execute back end, three cycles from accept to writeback.
// No loads, stores, csrs or traps. RESET_PC only fills bubble addresses.
module rv_exec_top #(
    parameter rv_exec_pkg::inst_addr_t RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    inst_valid_i,
    output logic                    inst_ready_o,
    input  rv_exec_pkg::inst_addr_t inst_addr_i,
    input  rv_exec_pkg::inst_t      inst_i,
    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output rv_exec_pkg::reg_addr_t  wb_waddr_o,
    output rv_exec_pkg::xlen_t      wb_wdata_o,
    output logic                    redirect_o,
    output rv_exec_pkg::inst_addr_t redirect_addr_o
);
    import rv_exec_pkg::*;

    cu_bus_t   cu;
    logic      gpr_we;
    reg_addr_t gpr_waddr;
    xlen_t     gpr_wdata;
    reg_addr_t gpr_raddr1, gpr_raddr2;
    xlen_t     gpr_rdata1, gpr_rdata2;

    dec_bus_if dec_bus_id ();    // decoder to pipe register
    dec_bus_if dec_bus_ex ();    // pipe register to execute

    inst_decoder #(.RESET_PC(RESET_PC)) u_inst_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_addr_i  (inst_addr_i),
        .inst_i       (inst_i),
        .cu_i         (cu),
        .dec_o        (dec_bus_id)
    );

    idu_id_pipe #(.RESET_PC(RESET_PC)) u_idu_id_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cu_i    (cu),
        .dec_i   (dec_bus_id),
        .dec_o   (dec_bus_ex)
    );

    exu_alu_stage u_exu_alu_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .dec_i           (dec_bus_ex),
        .wb_valid_o      (wb_valid_o),
        .wb_ready_i      (wb_ready_i),
        .wb_waddr_o      (wb_waddr_o),
        .wb_wdata_o      (wb_wdata_o),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .gpr_we_o        (gpr_we),
        .gpr_waddr_o     (gpr_waddr),
        .gpr_wdata_o     (gpr_wdata),
        .gpr_raddr1_o    (gpr_raddr1),
        .gpr_raddr2_o    (gpr_raddr2),
        .gpr_rdata1_i    (gpr_rdata1),
        .gpr_rdata2_i    (gpr_rdata2)
    );

    gpr_file u_gpr_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (gpr_we),
        .waddr_i  (gpr_waddr),
        .wdata_i  (gpr_wdata),
        .raddr1_i (gpr_raddr1),
        .raddr2_i (gpr_raddr2),
        .rdata1_o (gpr_rdata1),
        .rdata2_o (gpr_rdata2)
    );

    pipe_ctrl u_pipe_ctrl (
        .wb_valid_i (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .redirect_i (redirect_o),
        .cu_o       (cu)
    );

endmodule

//--- design/pipe_ctrl.sv
// Stall and flush from writeback back-pressure and redirect.
module pipe_ctrl (
    input  logic                 wb_valid_i,
    input  logic                 wb_ready_i,
    input  logic                 redirect_i,
    output rv_exec_pkg::cu_bus_t cu_o
);
    import rv_exec_pkg::*;

    logic stall;

    assign stall          = wb_valid_i & ~wb_ready_i;    // writeback held
    assign cu_o[CU_STALL] = stall;
    assign cu_o[CU_FLUSH] = redirect_i & ~stall;         // stall wins

endmodule

//--- design/exu_alu_stage.sv
// Execute stage with a one-entry writeback register. rd is written on acceptance,
// so the held entry forwards to the next instruction until then.
module exu_alu_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    dec_bus_if.snk                  dec_i,
    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output rv_exec_pkg::reg_addr_t  wb_waddr_o,
    output rv_exec_pkg::xlen_t      wb_wdata_o,
    output logic                    redirect_o,
    output rv_exec_pkg::inst_addr_t redirect_addr_o,
    output logic                    gpr_we_o,
    output rv_exec_pkg::reg_addr_t  gpr_waddr_o,
    output rv_exec_pkg::xlen_t      gpr_wdata_o,
    output rv_exec_pkg::reg_addr_t  gpr_raddr1_o,
    output rv_exec_pkg::reg_addr_t  gpr_raddr2_o,
    input  rv_exec_pkg::xlen_t      gpr_rdata1_i,
    input  rv_exec_pkg::xlen_t      gpr_rdata2_i
);
    import rv_exec_pkg::*;

    alu_op_e   alu_op;
    br_op_e    br_op;
    xlen_t     rs1_val, rs2_val;
    xlen_t     op1, op2;
    xlen_t     alu_res;
    xlen_t     jalr_sum;
    logic      is_jump;
    logic      taken;
    logic      wb_load;
    logic      wb_valid_q;
    reg_addr_t wb_waddr_q;
    xlen_t     wb_wdata_q;

    assign alu_op = alu_op_e'(dec_i.dec_info[DI_ALU_MSB:DI_ALU_LSB]);
    assign br_op  = br_op_e'(dec_i.dec_info[DI_BR_MSB:DI_BR_LSB]);

    assign gpr_raddr1_o = dec_i.reg1_raddr;
    assign gpr_raddr2_o = dec_i.reg2_raddr;
    // held rd never x0, so no zero check here
    assign rs1_val = (wb_valid_q && wb_waddr_q == dec_i.reg1_raddr) ? wb_wdata_q : gpr_rdata1_i;
    assign rs2_val = (wb_valid_q && wb_waddr_q == dec_i.reg2_raddr) ? wb_wdata_q : gpr_rdata2_i;

    assign op1 = dec_i.dec_info[DI_OP1_PC] ? dec_i.inst_addr : rs1_val;    // auipc
    assign op2 = dec_i.dec_info[DI_OP2_IMM] ? dec_i.dec_imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {31'b0, op1 < op2};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> op2[4:0];
            ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = op2;    // pass b
        endcase
    end

    always_comb begin
        case (br_op)
            BR_BEQ:  taken = (rs1_val == rs2_val);
            BR_BNE:  taken = (rs1_val != rs2_val);
            BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_BLTU: taken = (rs1_val < rs2_val);
            BR_BGEU: taken = (rs1_val >= rs2_val);
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump  = (br_op == BR_JAL) || (br_op == BR_JALR);
    assign jalr_sum = rs1_val + dec_i.dec_imm;
    assign redirect_addr_o = (br_op == BR_JALR) ? {jalr_sum[31:1], 1'b0}
                                                : dec_i.inst_addr + dec_i.dec_imm;

    assign wb_load    = ~wb_valid_q | wb_ready_i;          // slot empty or draining
    assign redirect_o = dec_i.valid & taken & wb_load;    // only as the entry moves on

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else if (wb_load) begin
            wb_valid_q <= dec_i.valid & dec_i.reg_we;    // branches and bubbles leave it empty
        end
    end

    always_ff @(posedge clk) begin
        if (wb_load) begin
            wb_waddr_q <= dec_i.reg_waddr;
            wb_wdata_q <= is_jump ? dec_i.inst_addr + 32'd4 : alu_res;    // link value
        end
    end

    assign wb_valid_o  = wb_valid_q;
    assign wb_waddr_o  = wb_waddr_q;
    assign wb_wdata_o  = wb_wdata_q;
    assign gpr_we_o    = wb_valid_q & wb_ready_i;    // commit on handshake
    assign gpr_waddr_o = wb_waddr_q;
    assign gpr_wdata_o = wb_wdata_q;

endmodule

//--- design/gpr_file.sv
// 32 x 32 register file, reads are combinational. x0 is never written.
module gpr_file (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   we_i,
    input  rv_exec_pkg::reg_addr_t waddr_i,
    input  rv_exec_pkg::xlen_t     wdata_i,
    input  rv_exec_pkg::reg_addr_t raddr1_i,
    input  rv_exec_pkg::reg_addr_t raddr2_i,
    output rv_exec_pkg::xlen_t     rdata1_o,
    output rv_exec_pkg::xlen_t     rdata2_o
);
    import rv_exec_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs <= '{default: '0};    // all cleared
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- design/idu_id_pipe.sv
// Decode/execute register. Holds on stall, loads a bubble on flush.
// Flush and stall never come together.
module idu_id_pipe #(
    parameter rv_exec_pkg::inst_addr_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rv_exec_pkg::cu_bus_t cu_i,
    dec_bus_if.snk               dec_i,
    dec_bus_if.src               dec_o
);
    import rv_exec_pkg::*;

    logic       stall;
    logic       flush;
    logic       valid_q;
    logic       reg_we_q;
    inst_addr_t addr_q;
    reg_addr_t  waddr_q;
    reg_addr_t  raddr1_q;
    reg_addr_t  raddr2_q;
    dec_info_t  info_q;
    xlen_t      imm_q;

    assign stall = cu_i[CU_STALL];
    assign flush = cu_i[CU_FLUSH];

    // control bits, cleared by reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            reg_we_q <= 1'b0;
        end else if (!stall) begin
            valid_q  <= dec_i.valid & ~flush;
            reg_we_q <= dec_i.reg_we & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            addr_q   <= flush ? RESET_PC : dec_i.inst_addr;
            waddr_q  <= flush ? '0 : dec_i.reg_waddr;
            raddr1_q <= flush ? '0 : dec_i.reg1_raddr;
            raddr2_q <= flush ? '0 : dec_i.reg2_raddr;
            info_q   <= flush ? '0 : dec_i.dec_info;    // zero is add, no branch
            imm_q    <= flush ? '0 : dec_i.dec_imm;
        end
    end

    assign dec_o.valid      = valid_q;
    assign dec_o.inst_addr  = addr_q;
    assign dec_o.reg_we     = reg_we_q;
    assign dec_o.reg_waddr  = waddr_q;
    assign dec_o.reg1_raddr = raddr1_q;
    assign dec_o.reg2_raddr = raddr2_q;
    assign dec_o.dec_info   = info_q;
    assign dec_o.dec_imm    = imm_q;

endmodule

//--- design/inst_decoder.sv
// Input register plus RV32I decode. A word taken during a flush is dropped.
// Opcodes outside OP-IMM/OP/LUI/AUIPC/JAL/JALR/branch decode to bubbles.
module inst_decoder #(
    parameter rv_exec_pkg::inst_addr_t RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    inst_valid_i,
    output logic                    inst_ready_o,
    input  rv_exec_pkg::inst_addr_t inst_addr_i,
    input  rv_exec_pkg::inst_t      inst_i,
    input  rv_exec_pkg::cu_bus_t    cu_i,
    dec_bus_if.src                  dec_o
);
    import rv_exec_pkg::*;

    logic       rdy_q;      // low through reset, then stays up
    logic       valid_q;
    inst_addr_t addr_q;
    inst_t      inst_q;
    logic       stall;
    logic       flush;
    logic       take;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t      imm;
    alu_op_e    alu_op;
    br_op_e     br_op;
    logic       op2_imm;
    logic       op1_pc;
    logic       has_rd;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    assign stall        = cu_i[CU_STALL];
    assign flush        = cu_i[CU_FLUSH];
    assign inst_ready_o = rdy_q & ~stall;    // hold off input while stalled
    assign take         = inst_valid_i & inst_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdy_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
            if (!stall) begin
                valid_q <= take & ~flush;    // younger than the redirect, discard
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            addr_q <= RESET_PC;    // bubble address
        end else if (take) begin
            addr_q <= inst_addr_i;
            inst_q <= inst_i;
        end
    end

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign rd     = inst_q[11:7];
    assign imm_i  = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s  = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b  = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_u  = {inst_q[31:12], 12'b0};
    assign imm_j  = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

    always_comb begin
        alu_op  = ALU_PASS_B;    // bubble info unless overridden
        br_op   = BR_NONE;
        op2_imm = 1'b0;
        op1_pc  = 1'b0;
        has_rd  = 1'b0;
        imm     = imm_i;
        case (opcode)
            OPC_OP_IMM: begin
                alu_op  = alu_sel(funct3, inst_q[30] & (funct3 == 3'b101));    // srai only
                op2_imm = 1'b1;
                has_rd  = 1'b1;
            end
            OPC_OP: begin
                alu_op = alu_sel(funct3, inst_q[30]);
                has_rd = 1'b1;
            end
            OPC_LUI: begin
                imm     = imm_u;
                op2_imm = 1'b1;
                has_rd  = 1'b1;
            end
            OPC_AUIPC: begin
                alu_op  = ALU_ADD;
                imm     = imm_u;
                op2_imm = 1'b1;
                op1_pc  = 1'b1;
                has_rd  = 1'b1;
            end
            OPC_JAL: begin
                br_op  = BR_JAL;
                imm    = imm_j;
                has_rd = 1'b1;
            end
            OPC_JALR: begin
                br_op  = BR_JALR;    // target rs1+imm built in execute
                has_rd = 1'b1;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  br_op = BR_BEQ;
                    3'b001:  br_op = BR_BNE;
                    3'b100:  br_op = BR_BLT;
                    3'b101:  br_op = BR_BGE;
                    3'b110:  br_op = BR_BLTU;
                    3'b111:  br_op = BR_BGEU;
                    default: br_op = BR_NONE;
                endcase
            end
            OPC_STORE: imm = imm_s;    // layout only, still a bubble
            default: ;
        endcase
    end

    assign dec_o.valid      = valid_q;
    assign dec_o.inst_addr  = addr_q;
    assign dec_o.reg_we     = valid_q & has_rd & (rd != '0);
    assign dec_o.reg_waddr  = rd;
    assign dec_o.reg1_raddr = inst_q[19:15];
    assign dec_o.reg2_raddr = inst_q[24:20];
    assign dec_o.dec_info   = {alu_op, br_op, op2_imm, op1_pc};
    assign dec_o.dec_imm    = imm;

endmodule

//--- design/dec_bus_if.sv
// Decoded bundle between pipeline stages. No csr fields.
interface dec_bus_if;
    import rv_exec_pkg::*;

    logic       valid;         // stage holds a live instruction
    inst_addr_t inst_addr;
    logic       reg_we;        // writes rd, never set for x0
    reg_addr_t  reg_waddr;
    reg_addr_t  reg1_raddr;    // indexes travel, not data
    reg_addr_t  reg2_raddr;
    dec_info_t  dec_info;
    xlen_t      dec_imm;       // sign extended

    modport src (
        output valid, inst_addr, reg_we, reg_waddr,
        output reg1_raddr, reg2_raddr, dec_info, dec_imm
    );

    modport snk (
        input valid, inst_addr, reg_we, reg_waddr,
        input reg1_raddr, reg2_raddr, dec_info, dec_imm
    );

endinterface

//--- design/rv_exec_pkg.sv
// Shared widths, encodings and bit positions for the RV32I execute back end.
// dec_info_t is a plain vector, so fields are read by the DI_* positions below.
package rv_exec_pkg;

    typedef logic [31:0] inst_addr_t;    // instruction address
    typedef logic [31:0] inst_t;         // raw instruction word
    typedef logic [31:0] xlen_t;         // general register data
    typedef logic [4:0]  reg_addr_t;     // x0..x31

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B    // lui, and the value for anything unsupported
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_e;

    // decode info, {alu_op, br_op, op2_imm, op1_pc}
    typedef logic [9:0] dec_info_t;
    localparam int DI_ALU_MSB = 9;
    localparam int DI_ALU_LSB = 6;
    localparam int DI_BR_MSB  = 5;
    localparam int DI_BR_LSB  = 2;
    localparam int DI_OP2_IMM = 1;    // operand b is the immediate
    localparam int DI_OP1_PC  = 0;    // operand a is the pc

    typedef logic [1:0] cu_bus_t;     // pipeline control
    localparam int CU_STALL = 0;
    localparam int CU_FLUSH = 1;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage
